// File: vic20_loader.f
rtl/loader_pkg.sv
rtl/dl_intake.sv
rtl/load_mapper.sv
rtl/wr_queue.sv
rtl/vic20_loader.sv
dv/vic20_loader_chk.sv
dv/vic20_loader_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module vic20_loader_tb \
    -Mdir obj_dir \
    -f vic20_loader.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vvic20_loader_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

// File: dv/loader_tests.txt
// Header: index, no-load-address flag, beat count, write count, reset pulses
// Beats {offset[15:0], data}, then writes {internal, addr[23:0], data}
5
// ROM over all eight banks
00 0 8 4 0
001011 3FFF12 400021 7FFF3F 81234A BABC5C C00566 F00077
100E00021 100FFFF3F 100C1234A 1008ABC5C
// PRG with header, load at $1001
01 0 6 12 0
000001 000110 0002A9 000300 00048D 00054C
1001001A9 100100200 10010038D 10010044C
100002D05 100002E10 100002F05 100003010
100003105 100003210 10000AE05 10000AF10
// Headerless cartridge at $A000
41 1 4 12 1
000009 0001A0 0002C3 0003C2
000A00009 000A001A0 000A002C3 000A003C2
100002D04 100002EA0 100002F04 1000030A0
100003104 1000032A0 10000AE04 10000AFA0
// PRG at $0FFE crossing into the $1000 block
01 0 6 12 0
0000FE 00010F 000211 000322 000433 000544
000000FFE11 000000FFF22 100100033 100100144
100002D02 100002E10 100002F02 100003010
100003102 100003210 10000AE02 10000AF10
// TAP image into SDRAM
81 0 5 5 0
000043 000136 000234 00032D 000454
002000043 002000136 002000234 00200032D 002000454

// File: dv/vic20_loader_tb.sv
`timescale 1ns/1ps

module vic20_loader_tb import loader_pkg::*; ();

    localparam int CLK_PERIOD    = 40;
    localparam int SETTLE_CYCLES = 16;

    logic       clk_sys;
    logic       reset;
    logic       dl_valid;
    logic       dl_ready;
    dl_beat_t   dl_beat;
    logic       dl_active;
    logic [7:0] dl_index;
    logic       no_load_addr;
    logic       mem_wr_valid;
    logic       mem_wr_ready;
    mem_wr_t    mem_wr;
    logic       force_reset;

    // Test words: headers, beats and write records
    logic [35:0] tmem [0:255];
    mem_wr_t     exp_q [$];
    int          got_cnt;
    int          rst_cnt;
    int          err_cnt;
    int          chk_cnt;
    int          test_num;
    int          wd_cycles;
    integer      seed = 30;

    vic20_loader #(
        .QUEUE_DEPTH (4)
    ) u_dut (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .dl_valid_i     (dl_valid),
        .dl_ready_o     (dl_ready),
        .dl_beat_i      (dl_beat),
        .dl_active_i    (dl_active),
        .dl_index_i     (dl_index),
        .no_load_addr_i (no_load_addr),
        .mem_wr_valid_o (mem_wr_valid),
        .mem_wr_ready_i (mem_wr_ready),
        .mem_wr_o       (mem_wr),
        .force_reset_o  (force_reset)
    );

    initial clk_sys = 1'b0;
    always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

    // Count fields hold decimal digits, one per nibble
    function automatic int count_at(input int pos);
        int val;
        int d;
        val = 0;
        for (d = 3; d >= 0; d--) begin
            val = val * 10 + int'(tmem[pos][d*4 +: 4]);
        end
        return val;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            $display("CHECK FAILED test %0d write %0d %s: got %h expected %h",
                     test_num, got_cnt, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_write(input mem_wr_t got);
        mem_wr_t exp;
        if (got_cnt >= exp_q.size()) begin
            $display("Test %0d: unexpected extra write to address %h", test_num, got.addr);
            err_cnt++;
        end else begin
            exp = exp_q[got_cnt];
            compare_field("mem_wr_o.addr", {9'd0, got.addr}, {9'd0, exp.addr});
            compare_field("mem_wr_o.data", {24'd0, got.data}, {24'd0, exp.data});
            compare_field("mem_wr_o.internal", {31'd0, got.internal}, {31'd0, exp.internal});
        end
        got_cnt++;
    endtask

    // Holds the beat until the intake takes it
    task automatic send_beat(input dl_beat_t b);
        logic taken;
        dl_valid = 1'b1;
        dl_beat  = b;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk_sys);
            taken = dl_ready;
            @(posedge clk_sys);
            #2;
        end
        dl_valid = 1'b0;
    endtask

    // Memory side stalls about one cycle in four
    always @(posedge clk_sys) begin
        #2;
        mem_wr_ready = ($random(seed) & 3) != 0;
    end

    // Collector for accepted writes and reset pulses
    always @(negedge clk_sys) begin
        if (!reset) begin
            if (force_reset) begin
                rst_cnt = rst_cnt + 1;
            end
            if (mem_wr_valid && mem_wr_ready) begin
                check_write(mem_wr);
            end
        end
    end

    initial begin
        wait (wd_cycles != 0);
        repeat (wd_cycles) @(posedge clk_sys);
        $display("Timeout after %0d cycles: test %0d saw %0d of %0d writes",
                 wd_cycles, test_num, got_cnt, exp_q.size());
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int      t;
        int      i;
        int      pos;
        int      nb;
        int      nw;
        int      exp_rst;
        int      total;
        int      n_tests;
        int      err_before;
        mem_wr_t w;

        reset        = 1'b1;
        dl_valid     = 1'b0;
        dl_beat      = '0;
        dl_active    = 1'b0;
        dl_index     = 8'd0;
        no_load_addr = 1'b0;
        mem_wr_ready = 1'b1;
        got_cnt      = 0;
        rst_cnt      = 0;
        err_cnt      = 0;
        chk_cnt      = 0;
        test_num     = 0;
        wd_cycles    = 0;

        $readmemh("dv/loader_tests.txt", tmem);
        n_tests = count_at(0);

        // Run length budget from the byte count
        total = 0;
        pos   = 1;
        for (t = 0; t < n_tests; t++) begin
            total += count_at(pos + 2);
            pos   += 5 + count_at(pos + 2) + count_at(pos + 3);
        end
        wd_cycles = total * 20 + 200;

        repeat (2) @(posedge clk_sys);
        #2;
        reset = 1'b0;

        pos = 1;
        for (t = 0; t < n_tests; t++) begin
            nb         = count_at(pos + 2);
            nw         = count_at(pos + 3);
            exp_rst    = count_at(pos + 4);
            test_num   = t + 1;
            err_before = err_cnt;
            got_cnt    = 0;
            rst_cnt    = 0;
            exp_q.delete();
            for (i = 0; i < nw; i++) begin
                w.internal = tmem[pos + 5 + nb + i][32];
                w.addr     = tmem[pos + 5 + nb + i][30:8];
                w.data     = tmem[pos + 5 + nb + i][7:0];
                exp_q.push_back(w);
            end

            dl_index     = tmem[pos][7:0];
            no_load_addr = tmem[pos + 1][0];
            dl_active    = 1'b1;
            for (i = 0; i < nb; i++) begin
                send_beat(tmem[pos + 5 + i][23:0]);
            end
            dl_active = 1'b0;

            while (got_cnt < nw) begin
                @(posedge clk_sys);
                #2;
            end
            repeat (SETTLE_CYCLES) @(posedge clk_sys);
            #2;

            chk_cnt += 2;
            if (got_cnt != nw) begin
                $display("Test %0d: expected %0d writes but saw %0d", test_num, nw, got_cnt);
                err_cnt++;
            end
            if (rst_cnt != exp_rst) begin
                $display("Test %0d: expected %0d reset pulse(s) but saw %0d",
                         test_num, exp_rst, rst_cnt);
                err_cnt++;
            end
            if (err_cnt == err_before) begin
                $display("Test %0d index %h: %0d writes, %0d reset pulse(s), ok",
                         test_num, dl_index, got_cnt, rst_cnt);
            end else begin
                $display("Test %0d index %h: %0d error(s)",
                         test_num, dl_index, err_cnt - err_before);
            end
            pos += 5 + nb + nw;
        end

        $display("Tests: %0d, checks: %0d, errors: %0d", n_tests, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: dv/vic20_loader_chk.sv
`timescale 1ns/1ps

module vic20_loader_chk import loader_pkg::*; (
    input logic    clk_sys,
    input logic    reset,
    input logic    mem_wr_valid_o,
    input logic    mem_wr_ready_i,
    input mem_wr_t mem_wr_o,
    input logic    force_reset_o
);

    // A stalled write keeps its content until taken
    a_hold_on_stall: assert property (@(posedge clk_sys) disable iff (reset)
        (mem_wr_valid_o && !mem_wr_ready_i) |=> (mem_wr_valid_o && $stable(mem_wr_o)))
        else $error("mem_wr_o changed or dropped while stalled");

    // Reset request is a single-cycle pulse
    a_reset_pulse: assert property (@(posedge clk_sys) disable iff (reset)
        force_reset_o |=> !force_reset_o)
        else $error("force_reset_o high for two cycles in a row");

    a_quiet_in_reset: assert property (@(posedge clk_sys)
        reset |=> (!mem_wr_valid_o && !force_reset_o))
        else $error("output active during reset");

endmodule

bind vic20_loader vic20_loader_chk u_chk (
    .clk_sys        (clk_sys),
    .reset          (reset),
    .mem_wr_valid_o (mem_wr_valid_o),
    .mem_wr_ready_i (mem_wr_ready_i),
    .mem_wr_o       (mem_wr_o),
    .force_reset_o  (force_reset_o)
);

// File: rtl/vic20_loader.sv
`timescale 1ns/1ps

module vic20_loader import loader_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       dl_valid_i,
    output logic       dl_ready_o,
    input  dl_beat_t   dl_beat_i,
    input  logic       dl_active_i,
    input  logic [7:0] dl_index_i,
    input  logic       no_load_addr_i,
    output logic       mem_wr_valid_o,
    input  logic       mem_wr_ready_i,
    output mem_wr_t    mem_wr_o,
    output logic       force_reset_o
);

    // Intake to mapper
    logic     beat_valid;
    logic     beat_ready;
    dl_beat_t beat;
    dl_kind_t kind;
    logic     dl_end;

    // Mapper to queue
    logic    req_valid;
    logic    req_ready;
    mem_wr_t req;

    dl_intake u_intake (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .dl_valid_i   (dl_valid_i),
        .dl_ready_o   (dl_ready_o),
        .dl_beat_i    (dl_beat_i),
        .dl_active_i  (dl_active_i),
        .dl_index_i   (dl_index_i),
        .beat_valid_o (beat_valid),
        .beat_ready_i (beat_ready),
        .beat_o       (beat),
        .kind_o       (kind),
        .dl_end_o     (dl_end)
    );

    load_mapper u_mapper (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .beat_valid_i   (beat_valid),
        .beat_ready_o   (beat_ready),
        .beat_i         (beat),
        .kind_i         (kind),
        .dl_end_i       (dl_end),
        .no_load_addr_i (no_load_addr_i),
        .req_valid_o    (req_valid),
        .req_ready_i    (req_ready),
        .req_o          (req),
        .force_reset_o  (force_reset_o)
    );

    wr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk_sys    (clk_sys),
        .reset      (reset),
        .wr_valid_i (req_valid),
        .wr_ready_o (req_ready),
        .wr_i       (req),
        .wr_valid_o (mem_wr_valid_o),
        .wr_ready_i (mem_wr_ready_i),
        .wr_o       (mem_wr_o)
    );

endmodule

// File: rtl/wr_queue.sv
`timescale 1ns/1ps

module wr_queue import loader_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic    clk_sys,
    input  logic    reset,
    input  logic    wr_valid_i,
    output logic    wr_ready_o,
    input  mem_wr_t wr_i,
    output logic    wr_valid_o,
    input  logic    wr_ready_i,
    output mem_wr_t wr_o
);

    // Depth of at least 2 expected
    localparam int               PTR_W    = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(QUEUE_DEPTH - 1);
    localparam logic [PTR_W:0]   CNT_FULL = (PTR_W + 1)'(QUEUE_DEPTH);

    mem_wr_t          mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == CNT_FULL);
    assign empty = (count == '0);

    assign wr_ready_o = !full;
    assign wr_valid_o = !empty;
    assign wr_o       = mem[rd_ptr];

    assign push = wr_valid_i && wr_ready_o;
    assign pop  = wr_valid_o && wr_ready_i;

    always_ff @(posedge clk_sys) begin
        if (push) begin
            mem[wr_ptr] <= wr_i;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leaves the level alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/load_mapper.sv
`timescale 1ns/1ps

module load_mapper import loader_pkg::*; (
    input  logic     clk_sys,
    input  logic     reset,
    input  logic     beat_valid_i,
    output logic     beat_ready_o,
    input  dl_beat_t beat_i,
    input  dl_kind_t kind_i,
    input  logic     dl_end_i,
    input  logic     no_load_addr_i,
    output logic     req_valid_o,
    input  logic     req_ready_i,
    output mem_wr_t  req_o,
    output logic     force_reset_o
);

    dl_offset_u  off_u;
    rom_win_t    win;
    mem_wr_t     beat_wr;
    logic        beat_wr_en;
    mem_wr_t     ptr_wr;
    logic [15:0] prg_addr;
    logic [15:0] load_addr;
    logic [15:0] data_cnt;
    logic [15:0] end_ptr;
    logic        auto_reset;
    logic        slot_free;
    logic        take_beat;
    logic        take_ptr;
    logic        inj_active;
    logic [2:0]  inj_idx;
    logic        req_last;

    // Block RAM regions: low RAM, 4K at $1000, colour RAM
    function automatic logic prg_is_internal(input logic [15:0] addr);
        return (addr[15:10] == 6'b000000) ||
               (addr[15:12] == 4'h1) ||
               (addr[15:10] == 6'b100101);
    endfunction

    assign slot_free    = !req_valid_o || req_ready_i;
    assign beat_ready_o = slot_free && !inj_active && !dl_end_i;
    assign take_beat    = beat_valid_i && beat_ready_o;
    assign take_ptr     = inj_active && slot_free;

    assign end_ptr    = load_addr + data_cnt;
    assign auto_reset = (load_addr == CART_LOAD_ADDR);

    // ==================================================================
    // Per-beat address mapping
    // ==================================================================

    always_comb begin
        off_u      = beat_i.offset;
        win        = ROM_BANK_BASE[off_u.rom.bank];
        beat_wr    = '0;
        beat_wr_en = 1'b0;
        if (no_load_addr_i) begin
            prg_addr = CART_LOAD_ADDR + off_u.flat;
        end else begin
            prg_addr = load_addr + off_u.flat - 16'd2;
        end

        case (kind_i)
            DL_ROM: begin
                beat_wr_en       = win.en;
                beat_wr.internal = 1'b1;
                if (win.narrow) begin
                    beat_wr.addr = {7'd0, win.base | {4'd0, off_u.rom.ofs[11:0]}};
                end else begin
                    beat_wr.addr = {7'd0, win.base | {3'd0, off_u.rom.ofs}};
                end
            end
            DL_PRG: begin
                // First two bytes are the load address unless headerless
                beat_wr_en       = no_load_addr_i || (off_u.flat > 16'd1);
                beat_wr.addr     = {7'd0, prg_addr};
                beat_wr.internal = prg_is_internal(prg_addr);
            end
            DL_TAP: begin
                beat_wr_en       = 1'b1;
                beat_wr.addr     = TAP_MEM_START + {7'd0, off_u.flat};
                beat_wr.internal = 1'b0;
            end
            default: begin
                beat_wr_en = 1'b0;
            end
        endcase

        beat_wr.data = beat_i.data;
    end

    // Pointer writes alternate low and high byte
    always_comb begin
        ptr_wr.addr     = {7'd0, PTR_ADDRS[inj_idx]};
        ptr_wr.data     = inj_idx[0] ? end_ptr[15:8] : end_ptr[7:0];
        ptr_wr.internal = 1'b1;
    end

    // ==================================================================
    // Control
    // ==================================================================

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            req_valid_o   <= 1'b0;
            req_last      <= 1'b0;
            inj_active    <= 1'b0;
            inj_idx       <= 3'd0;
            force_reset_o <= 1'b0;
        end else begin
            force_reset_o <= 1'b0;

            if (take_beat) begin
                req_valid_o <= beat_wr_en;
                req_last    <= 1'b0;
            end else if (take_ptr) begin
                req_valid_o <= 1'b1;
                req_last    <= (inj_idx == 3'd7);
            end else if (req_ready_i) begin
                req_valid_o <= 1'b0;
                req_last    <= 1'b0;
            end

            if (dl_end_i && kind_i == DL_PRG) begin
                inj_active <= 1'b1;
                inj_idx    <= 3'd0;
            end else if (take_ptr) begin
                inj_idx <= inj_idx + 3'd1;
                if (inj_idx == 3'd7) begin
                    inj_active <= 1'b0;
                end
            end

            // Restart the machine once the last pointer is handed on
            if (req_valid_o && req_ready_i && req_last) begin
                force_reset_o <= auto_reset;
            end
        end
    end

    // Load address and data count of the current PRG
    always_ff @(posedge clk_sys) begin
        if (take_beat && kind_i == DL_PRG) begin
            if (no_load_addr_i) begin
                if (off_u.flat == 16'd0) begin
                    load_addr <= CART_LOAD_ADDR;
                    data_cnt  <= 16'd1;
                end else begin
                    data_cnt <= data_cnt + 16'd1;
                end
            end else if (off_u.flat == 16'd0) begin
                load_addr[7:0] <= beat_i.data;
                data_cnt       <= 16'd0;
            end else if (off_u.flat == 16'd1) begin
                load_addr[15:8] <= beat_i.data;
            end else begin
                data_cnt <= data_cnt + 16'd1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (take_ptr) begin
            req_o <= ptr_wr;
        end else if (take_beat) begin
            req_o <= beat_wr;
        end
    end

endmodule

// File: rtl/dl_intake.sv
`timescale 1ns/1ps

module dl_intake import loader_pkg::*; (
    input  logic       clk_sys,
    input  logic       reset,
    input  logic       dl_valid_i,
    output logic       dl_ready_o,
    input  dl_beat_t   dl_beat_i,
    input  logic       dl_active_i,
    input  logic [7:0] dl_index_i,
    output logic       beat_valid_o,
    input  logic       beat_ready_i,
    output dl_beat_t   beat_o,
    output dl_kind_t   kind_o,
    output logic       dl_end_o
);

    dl_kind_t kind_in;
    logic     slot_free;
    logic     accept;
    logic     active_q;
    logic     end_pend;

    assign kind_in   = dl_kind_decode(dl_index_i);
    assign slot_free = !beat_valid_o || beat_ready_i;

    // Hold off the host until the finished download has been closed
    assign dl_ready_o = slot_free && !end_pend;
    assign accept     = dl_valid_i && dl_ready_o;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            beat_valid_o <= 1'b0;
            kind_o       <= DL_NONE;
            active_q     <= 1'b0;
            end_pend     <= 1'b0;
            dl_end_o     <= 1'b0;
        end else begin
            active_q <= dl_active_i;
            dl_end_o <= 1'b0;

            // Beats of an unknown kind are swallowed here
            if (accept) begin
                beat_valid_o <= (kind_in != DL_NONE);
            end else if (beat_ready_i) begin
                beat_valid_o <= 1'b0;
            end

            // Kind tracks the held beat and survives past the end
            if (dl_active_i && slot_free) begin
                kind_o <= kind_in;
            end

            // End only once the last beat has moved on
            if (active_q && !dl_active_i) begin
                end_pend <= 1'b1;
            end else if (end_pend && !beat_valid_o) begin
                end_pend <= 1'b0;
                dl_end_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (accept) begin
            beat_o <= dl_beat_i;
        end
    end

endmodule

// File: rtl/loader_pkg.sv
package loader_pkg;

    // ==================================================================
    // Download kinds and host beat
    // ==================================================================

    typedef enum logic [1:0] {
        DL_ROM  = 2'd0,
        DL_PRG  = 2'd1,
        DL_TAP  = 2'd2,
        DL_NONE = 2'd3
    } dl_kind_t;

    typedef struct packed {
        logic [15:0] offset;
        logic [7:0]  data;
    } dl_beat_t;

    // Same offset word, seen as ROM bank + offset or as a plain byte count
    typedef union packed {
        struct packed {
            logic [2:0]  bank;
            logic [12:0] ofs;
        } rom;
        logic [15:0] flat;
    } dl_offset_u;

    // One memory write; internal selects block RAM over SDRAM
    typedef struct packed {
        logic [22:0] addr;
        logic [7:0]  data;
        logic        internal;
    } mem_wr_t;

    // ROM window entry, narrow windows take only 12 offset bits
    typedef struct packed {
        logic        en;
        logic        narrow;
        logic [15:0] base;
    } rom_win_t;

    // ==================================================================
    // Memory map
    // ==================================================================

    localparam logic [22:0] TAP_MEM_START  = 23'h020000;
    localparam logic [15:0] CART_LOAD_ADDR = 16'hA000;

    // BASIC zero-page pointers that receive the end of program
    localparam logic [15:0] PTR_ADDRS [8] = '{
        16'h002D, 16'h002E, 16'h002F, 16'h0030,
        16'h0031, 16'h0032, 16'h00AE, 16'h00AF
    };

    // Banks 0/1 hold the 1541 image, 6/7 are unused
    localparam rom_win_t ROM_BANK_BASE [8] = '{
        '{1'b0, 1'b0, 16'h0000},
        '{1'b0, 1'b0, 16'h0000},
        '{1'b1, 1'b0, 16'hE000},
        '{1'b1, 1'b0, 16'hE000},
        '{1'b1, 1'b0, 16'hC000},
        '{1'b1, 1'b1, 16'h8000},
        '{1'b0, 1'b0, 16'h0000},
        '{1'b0, 1'b0, 16'h0000}
    };

    function automatic dl_kind_t dl_kind_decode(input logic [7:0] index);
        case (index)
            8'h00:        return DL_ROM;
            8'h01, 8'h41: return DL_PRG;
            8'h81:        return DL_TAP;
            default:      return DL_NONE;
        endcase
    endfunction

endpackage
